/* verilog/adder_cfg_pkg.sv */
// operand width, word type and pipeline depth shared by the adder top level and its testbench
package adder_cfg_pkg;

   // default operand width, any power of two from 16 up
   localparam int DEF_WIDTH = 64;

   // register stages between the inputs and the outputs
   localparam int PIPE_DEPTH = 4;

   // operand or sum at the default width
   typedef logic [DEF_WIDTH-1:0] word_t;

endpackage

/* verilog/prefix_tree_pkg.sv */
// carry-tree geometry for the Brent-Kung / Kogge-Stone stages, imported by each tree stage
package prefix_tree_pkg;

   // Brent-Kung up-sweep levels ahead of the Kogge-Stone spans
   localparam int BK_LEVELS = 2;

   // span held by each group position once the up-sweep is done
   localparam int GROUP_SIZE = 1 << BK_LEVELS;

   // Kogge-Stone levels needed to cover all group positions
   function automatic int ks_levels(input int width);
      return $clog2(width / GROUP_SIZE);
   endfunction

endpackage

/* verilog/pg_stage.sv */
// first adder pipeline stage, registers the propagate and generate vectors with cin at position 0
`timescale 1ns/100ps

module pg_stage #(
   parameter int WIDTH = 64
) (
   input  logic             clk,
   input  logic             rst_n,
   input  logic             in_valid,
   input  logic [WIDTH-1:0] a,
   input  logic [WIDTH-1:0] b,
   input  logic             cin,
   output logic             valid,
   output logic [WIDTH:0]   gp_g,
   output logic [WIDTH:0]   gp_p,
   output logic [WIDTH-1:0] p_bits
);

   logic [WIDTH-1:0] xor_bits;
   logic [WIDTH-1:0] and_bits;

   assign xor_bits = a ^ b;
   assign and_bits = a & b;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         valid <= 1'b0;
      end else begin
         valid <= in_valid;
      end
   end

   // carry-in acts as a generate that nothing can propagate through
   always_ff @(posedge clk) begin
      if (in_valid) begin
         gp_g   <= {and_bits, cin};
         gp_p   <= {xor_bits, 1'b0};
         p_bits <= xor_bits;
      end
   end

endmodule

/* verilog/bk_reduce_stage.sv */
// second adder pipeline stage, Brent-Kung up-sweep that builds pair and group-of-four prefixes
`timescale 1ns/100ps

module bk_reduce_stage import prefix_tree_pkg::*; #(
   parameter int WIDTH = 64
) (
   input  logic             clk,
   input  logic             rst_n,
   input  logic             valid_in,
   input  logic [WIDTH:0]   gp_g_in,
   input  logic [WIDTH:0]   gp_p_in,
   input  logic [WIDTH-1:0] p_bits_in,
   output logic             valid,
   output logic [WIDTH:0]   gp_g,
   output logic [WIDTH:0]   gp_p,
   output logic [WIDTH-1:0] p_bits
);

   logic [WIDTH:0] g_lvl [0:BK_LEVELS];
   logic [WIDTH:0] p_lvl [0:BK_LEVELS];

   // level l joins the top of each 2d block with the position d below
   always_comb begin
      g_lvl[0] = gp_g_in;
      p_lvl[0] = gp_p_in;
      for (int l = 0; l < BK_LEVELS; l++) begin
         g_lvl[l+1] = g_lvl[l];
         p_lvl[l+1] = p_lvl[l];
         for (int i = 0; i <= WIDTH; i++) begin
            if (i % (GROUP_SIZE >> (BK_LEVELS - l - 1)) ==
                (GROUP_SIZE >> (BK_LEVELS - l - 1)) - 1) begin
               g_lvl[l+1][i] = g_lvl[l][i] |
                               (p_lvl[l][i] & g_lvl[l][i - (GROUP_SIZE >> (BK_LEVELS - l))]);
               p_lvl[l+1][i] = p_lvl[l][i] & p_lvl[l][i - (GROUP_SIZE >> (BK_LEVELS - l))];
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         valid <= 1'b0;
      end else begin
         valid <= valid_in;
      end
   end

   always_ff @(posedge clk) begin
      if (valid_in) begin
         gp_g   <= g_lvl[BK_LEVELS];
         gp_p   <= p_lvl[BK_LEVELS];
         p_bits <= p_bits_in;
      end
   end

endmodule

/* verilog/ks_span_stage.sv */
// third adder pipeline stage, Kogge-Stone spans across the group-of-four positions
`timescale 1ns/100ps

module ks_span_stage import prefix_tree_pkg::*; #(
   parameter int WIDTH = 64
) (
   input  logic             clk,
   input  logic             rst_n,
   input  logic             valid_in,
   input  logic [WIDTH:0]   gp_g_in,
   input  logic [WIDTH:0]   gp_p_in,
   input  logic [WIDTH-1:0] p_bits_in,
   output logic             valid,
   output logic [WIDTH:0]   gp_g,
   output logic [WIDTH:0]   gp_p,
   output logic [WIDTH-1:0] p_bits
);

   localparam int KS_N = ks_levels(WIDTH);

   logic [WIDTH:0] g_lvl [0:KS_N];
   logic [WIDTH:0] p_lvl [0:KS_N];

   // every level reads only the previous one, so all spans at a level run in parallel
   always_comb begin
      g_lvl[0] = gp_g_in;
      p_lvl[0] = gp_p_in;
      for (int k = 0; k < KS_N; k++) begin
         g_lvl[k+1] = g_lvl[k];
         p_lvl[k+1] = p_lvl[k];
         for (int i = 0; i <= WIDTH; i++) begin
            if ((i % GROUP_SIZE == GROUP_SIZE - 1) && (i >= (GROUP_SIZE << k))) begin
               g_lvl[k+1][i] = g_lvl[k][i] | (p_lvl[k][i] & g_lvl[k][i - (GROUP_SIZE << k)]);
               p_lvl[k+1][i] = p_lvl[k][i] & p_lvl[k][i - (GROUP_SIZE << k)];
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         valid <= 1'b0;
      end else begin
         valid <= valid_in;
      end
   end

   // group positions now carry the full prefix from cin
   always_ff @(posedge clk) begin
      if (valid_in) begin
         gp_g   <= g_lvl[KS_N];
         gp_p   <= p_lvl[KS_N];
         p_bits <= p_bits_in;
      end
   end

endmodule

/* verilog/sum_stage.sv */
// last adder pipeline stage, Brent-Kung fill of the remaining carries and the registered sum
`timescale 1ns/100ps

module sum_stage import prefix_tree_pkg::*; #(
   parameter int WIDTH = 64
) (
   input  logic             clk,
   input  logic             rst_n,
   input  logic             valid_in,
   input  logic [WIDTH:0]   gp_g_in,
   input  logic [WIDTH:0]   gp_p_in,
   input  logic [WIDTH-1:0] p_bits_in,
   output logic             out_valid,
   output logic [WIDTH-1:0] sum,
   output logic             cout
);

   logic [WIDTH:0] g_fill [0:BK_LEVELS];

   // down-sweep, first half-group then single steps
   // each step touches positions no later step revisits, so the input propagates suffice
   always_comb begin
      g_fill[0] = gp_g_in;
      for (int l = 0; l < BK_LEVELS; l++) begin
         g_fill[l+1] = g_fill[l];
         for (int i = 0; i <= WIDTH; i++) begin
            if ((i % (GROUP_SIZE >> l) == (GROUP_SIZE >> (l + 1)) - 1) &&
                (i >= (GROUP_SIZE >> (l + 1)))) begin
               g_fill[l+1][i] = g_fill[l][i] |
                                (gp_p_in[i] & g_fill[l][i - (GROUP_SIZE >> (l + 1))]);
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         out_valid <= 1'b0;
      end else begin
         out_valid <= valid_in;
      end
   end

   // position k holds the carry into operand bit k
   always_ff @(posedge clk) begin
      if (valid_in) begin
         sum  <= p_bits_in ^ g_fill[BK_LEVELS][WIDTH-1:0];
         cout <= g_fill[BK_LEVELS][WIDTH];
      end
   end

endmodule

/* verilog/prefix_adder_top.sv */
// four-stage pipelined hybrid prefix adder, top level instantiated by the testbench or a parent
`timescale 1ns/100ps

module prefix_adder_top import adder_cfg_pkg::*; #(
   parameter int WIDTH = DEF_WIDTH
) (
   input  logic             clk,
   input  logic             rst_n,
   input  logic             in_valid,
   input  logic [WIDTH-1:0] a,
   input  logic [WIDTH-1:0] b,
   input  logic             cin,
   output logic             out_valid,
   output logic [WIDTH-1:0] sum,
   output logic             cout
);

   logic             valid_pg;
   logic             valid_bk;
   logic             valid_ks;
   logic [WIDTH:0]   g_pg;
   logic [WIDTH:0]   p_pg;
   logic [WIDTH:0]   g_bk;
   logic [WIDTH:0]   p_bk;
   logic [WIDTH:0]   g_ks;
   logic [WIDTH:0]   p_ks;
   logic [WIDTH-1:0] xor_pg;
   logic [WIDTH-1:0] xor_bk;
   logic [WIDTH-1:0] xor_ks;

   pg_stage #(.WIDTH(WIDTH)) pg_stage_i (
      .clk(clk), .rst_n(rst_n), .in_valid(in_valid), .a(a), .b(b), .cin(cin),
      .valid(valid_pg), .gp_g(g_pg), .gp_p(p_pg), .p_bits(xor_pg)
   );

   bk_reduce_stage #(.WIDTH(WIDTH)) bk_reduce_stage_i (
      .clk(clk), .rst_n(rst_n), .valid_in(valid_pg),
      .gp_g_in(g_pg), .gp_p_in(p_pg), .p_bits_in(xor_pg),
      .valid(valid_bk), .gp_g(g_bk), .gp_p(p_bk), .p_bits(xor_bk)
   );

   ks_span_stage #(.WIDTH(WIDTH)) ks_span_stage_i (
      .clk(clk), .rst_n(rst_n), .valid_in(valid_bk),
      .gp_g_in(g_bk), .gp_p_in(p_bk), .p_bits_in(xor_bk),
      .valid(valid_ks), .gp_g(g_ks), .gp_p(p_ks), .p_bits(xor_ks)
   );

   sum_stage #(.WIDTH(WIDTH)) sum_stage_i (
      .clk(clk), .rst_n(rst_n), .valid_in(valid_ks),
      .gp_g_in(g_ks), .gp_p_in(p_ks), .p_bits_in(xor_ks),
      .out_valid(out_valid), .sum(sum), .cout(cout)
   );

endmodule

/* test/prefix_adder_chk.sv */
// assertions on the adder's valid timing and output values, bound into the top level
`timescale 1ns/100ps

module prefix_adder_chk import adder_cfg_pkg::*; #(
   parameter int WIDTH = DEF_WIDTH
) (
   input logic             clk,
   input logic             rst_n,
   input logic             in_valid,
   input logic             out_valid,
   input logic [WIDTH-1:0] sum,
   input logic             cout
);

   // edges with rst_n high since the last reset edge, saturating
   int since_rst = 0;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         since_rst <= 0;
      end else if (since_rst < PIPE_DEPTH) begin
         since_rst <= since_rst + 1;
      end
   end

   valid_delay: assert property (@(posedge clk)
      (since_rst >= PIPE_DEPTH) |-> (out_valid == $past(in_valid, PIPE_DEPTH)))
      else $error("out_valid differs from in_valid %0d cycles earlier", PIPE_DEPTH);

   after_reset: assert property (@(posedge clk) !rst_n |=> !out_valid)
      else $error("out_valid high in the cycle after a reset edge");

   known_result: assert property (@(posedge clk) out_valid |-> !$isunknown({sum, cout}))
      else $error("sum or cout has unknown bits while out_valid is high");

endmodule

bind prefix_adder_top prefix_adder_chk #(.WIDTH(WIDTH)) prefix_adder_chk_i (
   .clk(clk), .rst_n(rst_n), .in_valid(in_valid),
   .out_valid(out_valid), .sum(sum), .cout(cout)
);

/* test/prefix_adder_tb.sv */
// directed testbench for the pipelined prefix adder, run as the simulation top level
`timescale 1ns/100ps

module prefix_adder_tb import adder_cfg_pkg::*; ();

   localparam int WIDTH = DEF_WIDTH;
   localparam int RST_CYCLES = 16;
   localparam int N_RANDOM = 200;
   localparam int N_BUBBLE = 100;
   localparam int N_TESTS = 5;
   // input and idle cycles over all tests including reset mid-stream
   localparam int TEST_CYCLES = 5 + 2 * (WIDTH + 1) + N_RANDOM + N_BUBBLE + 20;
   localparam int MAX_CYCLES = 2 * (TEST_CYCLES + PIPE_DEPTH * N_TESTS + RST_CYCLES);

   logic clk;
   logic rst_n;
   logic in_valid;
   logic cin;
   logic out_valid;
   logic cout;
   word_t a;
   word_t b;
   word_t sum;

   logic [WIDTH:0] exp_q[$];
   logic [PIPE_DEPTH-1:0] valid_pipe;
   logic [15:0] lfsr_state;
   logic mon_on;
   int errors;
   int tests_pass;
   int tests_fail;
   int n_in;
   int n_out;
   int cycles;

   prefix_adder_top #(.WIDTH(WIDTH)) prefix_adder_top_i (
      .clk(clk), .rst_n(rst_n), .in_valid(in_valid), .a(a), .b(b), .cin(cin),
      .out_valid(out_valid), .sum(sum), .cout(cout)
   );

   always #10 clk = ~clk;

   always @(posedge clk) begin
      cycles++;
      if (cycles > MAX_CYCLES) begin
         $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
         $display("Test failures found");
         $finish;
      end
   end

   task automatic compare_word(input string name, input word_t expected, input word_t actual);
      if (actual !== expected) begin
         $display("ERROR %0t %s expected %h actual %h", $time, name, expected, actual);
         errors++;
      end
   endtask

   task automatic match_bit(input string name, input logic expected, input logic actual);
      if (actual !== expected) begin
         $display("ERROR %0t %s expected %b actual %b", $time, name, expected, actual);
         errors++;
      end
   endtask

   // reference model sampling the same port values as the DUT on this edge
   always @(posedge clk) begin
      logic [WIDTH:0] expected;
      if (mon_on) begin
         match_bit("out_valid", valid_pipe[PIPE_DEPTH-1], out_valid);
      end
      if (out_valid === 1'b1) begin
         n_out++;
         if (exp_q.size() == 0) begin
            $display("out_valid was high at %0t with no addition in flight", $time);
            errors++;
         end else begin
            expected = exp_q.pop_front();
            compare_word("sum", expected[WIDTH-1:0], sum);
            match_bit("cout", expected[WIDTH], cout);
         end
      end
      // a reset edge flushes every stage
      if (!rst_n) begin
         exp_q.delete();
         valid_pipe <= '0;
      end else begin
         valid_pipe <= {valid_pipe[PIPE_DEPTH-2:0], in_valid};
         if (in_valid) begin
            exp_q.push_back({1'b0, a} + {1'b0, b} + {{WIDTH{1'b0}}, cin});
            n_in++;
         end
      end
   end

   // Galois LFSR x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic lfsr_bit();
      logic out;
      out = lfsr_state[0];
      lfsr_state = lfsr_state >> 1;
      if (out) begin
         lfsr_state = lfsr_state ^ 16'hB400;
      end
      return out;
   endfunction

   function automatic word_t random_word();
      word_t w;
      for (int i = 0; i < WIDTH; i++) begin
         w[i] = lfsr_bit();
      end
      return w;
   endfunction

   task automatic send(input word_t x, input word_t y, input logic c);
      @(posedge clk);
      in_valid <= 1'b1;
      a <= x;
      b <= y;
      cin <= c;
   endtask

   task automatic idle(input int n);
      repeat (n) begin
         @(posedge clk);
         in_valid <= 1'b0;
      end
   endtask

   // wait until every addition in flight has come out
   task automatic drain();
      idle(1);
      while (exp_q.size() != 0) begin
         @(negedge clk);
      end
      idle(1);
      @(negedge clk);
   endtask

   task automatic report(input string name, input int errs_before);
      if (errors == errs_before) begin
         $display("PASS %s", name);
         tests_pass++;
      end else begin
         $display("FAIL %s with %0d errors", name, errors - errs_before);
         tests_fail++;
      end
   endtask

   task automatic corner_sums();
      int e0;
      word_t ones;
      e0 = errors;
      ones = '1;
      send('0, '0, 1'b0);
      send(ones, '0, 1'b1);
      send(ones, ones, 1'b0);
      send(ones, ones, 1'b1);
      send('0, '0, 1'b1);
      drain();
      report("corner_sums", e0);
   endtask

   task automatic carry_chains();
      int e0;
      word_t ones;
      e0 = errors;
      for (int k = 0; k <= WIDTH; k++) begin
         ones = {WIDTH{1'b1}} >> (WIDTH - k);
         send(ones, word_t'(1), 1'b0);
         send(ones, '0, 1'b1);
      end
      drain();
      report("carry_chains", e0);
   endtask

   task automatic random_stream();
      int e0;
      int in0;
      int out0;
      e0 = errors;
      in0 = n_in;
      out0 = n_out;
      for (int i = 0; i < N_RANDOM; i++) begin
         send(random_word(), random_word(), lfsr_bit());
      end
      drain();
      if (n_in - in0 != N_RANDOM || n_out - out0 != N_RANDOM) begin
         $display("random stream sent %0d additions and saw %0d results, %0d expected",
                  n_in - in0, n_out - out0, N_RANDOM);
         errors++;
      end
      report("random_stream", e0);
   endtask

   // out_valid pattern is checked on every edge by the model
   task automatic bubble_stream();
      int e0;
      e0 = errors;
      for (int i = 0; i < N_BUBBLE; i++) begin
         if (lfsr_bit()) begin
            send(random_word(), random_word(), lfsr_bit());
         end else begin
            idle(1);
         end
      end
      drain();
      report("bubble_stream", e0);
   endtask

   task automatic reset_mid_stream();
      int e0;
      int out0;
      e0 = errors;
      repeat (3) begin
         send(random_word(), random_word(), lfsr_bit());
      end
      @(posedge clk);
      in_valid <= 1'b0;
      rst_n <= 1'b0;
      @(negedge clk);
      out0 = n_out;
      idle(6);
      rst_n <= 1'b1;
      idle(8);
      @(negedge clk);
      if (n_out != out0) begin
         $display("results came out across the reset");
         errors++;
      end
      send(random_word(), random_word(), 1'b1);
      send(random_word(), random_word(), 1'b0);
      drain();
      report("reset_mid_stream", e0);
   endtask

   initial begin
      clk = 1'b0;
      rst_n <= 1'b0;
      in_valid <= 1'b0;
      a <= '0;
      b <= '0;
      cin <= 1'b0;
      lfsr_state = 16'd52151;
      mon_on = 1'b0;
      repeat (RST_CYCLES) @(posedge clk);
      rst_n <= 1'b1;
      @(negedge clk);
      mon_on = 1'b1;
      corner_sums();
      carry_chains();
      random_stream();
      bubble_stream();
      reset_mid_stream();
      $display("tests passed %0d, tests failed %0d", tests_pass, tests_fail);
      if (tests_fail == 0 && errors == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

endmodule

/* sources.f */
verilog/adder_cfg_pkg.sv
verilog/prefix_tree_pkg.sv
verilog/pg_stage.sv
verilog/bk_reduce_stage.sv
verilog/ks_span_stage.sv
verilog/sum_stage.sv
verilog/prefix_adder_top.sv
test/prefix_adder_chk.sv
test/prefix_adder_tb.sv

/* Makefile */
# Verilator build and run for the pipelined prefix adder

VERILATOR ?= verilator
TOP       ?= prefix_adder_tb
FILELIST  ?= sources.f
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= All tests passed!

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD) -f $(FILELIST)

# pass or fail is taken from the log, not from the simulator's exit code
run: $(SIM_BIN)
	-./$(SIM_BIN) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qx '$(PASS_MSG)' $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)
